// File: logic/controlPkg.sv
// Control unit shared types
package controlPkg;

	// ------------------------------------------------------------
	// widths
	// ------------------------------------------------------------
	localparam int instrWidth   = 8;  // one instruction byte
	localparam int counterWidth = 16; // free-running cycle count

	typedef logic [instrWidth-1:0]   instr_t;
	typedef logic [counterWidth-1:0] cycleCount_t;

	// ------------------------------------------------------------
	// decoded instruction and sequencer states
	// ------------------------------------------------------------
	typedef enum logic [3:0] {
		opAdd,
		opSub,
		opNand,
		opShift,
		opOri,
		opLoad,
		opStore,
		opBpz,
		opBz,
		opBnz,
		opStop,
		opNop,
		opUndefined    // includes the old vector encodings
	} opcode_t;

	typedef enum logic [3:0] {
		resetState,
		fetch,
		decode,
		execArith,     // add, sub, nand
		writeBack,     // shared by arith and shift
		execShift,
		oriRead,
		oriExec,
		oriWrite,
		loadRead,
		loadWrite,
		storeExec,
		branchExec,    // all three branches
		halted,
		nopExec
	} state_t;

	// ------------------------------------------------------------
	// datapath control encodings
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		aluAdd   = 3'd0,
		aluSub   = 3'd1,
		aluOr    = 3'd2,
		aluNand  = 3'd3,
		aluShift = 3'd4
	} aluOp_t;

	typedef enum logic [2:0] {
		srcReg       = 3'd0,
		srcOne       = 3'd1, // pc increment
		srcBranchImm = 3'd2,
		srcOriImm    = 3'd3,
		srcShiftImm  = 3'd4
	} aluSrc2_t;

	typedef struct packed {
		logic     pcWrite;
		logic     addrSel;
		logic     memRead;
		logic     memWrite;
		logic     irLoad;
		logic     r1Sel;
		logic     mdrLoad;
		logic     r1r2Load;
		logic     alu1;
		aluSrc2_t alu2;
		aluOp_t   aluOp;
		logic     aluOutWrite;
		logic     rfWrite;
		logic     regIn;
		logic     flagWrite;
	} controlWord_t;

	localparam controlWord_t idleControl = '0; // nothing written, nothing read

endpackage

// File: logic/instrDecoder.sv
// Instruction byte decoder
`timescale 1ns/1ps

module instrDecoder
(
	input  controlPkg::instr_t  instr,
	output controlPkg::opcode_t opcode
);
	import controlPkg::*;

	logic [3:0] lowNibble;
	logic [2:0] lowThree;

	assign lowNibble = instr[3:0];
	assign lowThree  = instr[2:0];

	// ------------------------------------------------------------
	// priority decode, first match wins
	// ------------------------------------------------------------
	always_comb
	begin
		if (lowNibble == 4'b0100)
			opcode = opAdd;
		else if (lowNibble == 4'b0110)
			opcode = opSub;
		else if (lowNibble == 4'b1000)
			opcode = opNand;
		else if (lowThree == 3'b011)
			opcode = opShift;  // shift amount in upper bits
		else if (lowThree == 3'b111)
			opcode = opOri;    // 5-bit immediate above
		else if (lowNibble == 4'b0000)
			opcode = opLoad;
		else if (lowNibble == 4'b0010)
			opcode = opStore;
		else if (lowNibble == 4'b1101)
			opcode = opBpz;
		else if (lowNibble == 4'b0101)
			opcode = opBz;
		else if (lowNibble == 4'b1001)
			opcode = opBnz;
		else if (instr == 8'b0000_0001)
			opcode = opStop;
		else if (instr == 8'b1000_0001)
			opcode = opNop;
		else
			opcode = opUndefined; // vector patterns land here too
	end

endmodule

// File: logic/stateSequencer.sv
// Multi-cycle state sequencer
`timescale 1ns/1ps

module stateSequencer
(
	input  logic                    clock,
	input  logic                    reset,
	input  controlPkg::opcode_t     opcode,
	output controlPkg::state_t      state,
	output controlPkg::cycleCount_t cycleCount
);
	import controlPkg::*;

	state_t nextState;

	// ------------------------------------------------------------
	// next-state logic
	// ------------------------------------------------------------
	always_comb
	begin
		nextState = state;
		case (state)
			resetState: nextState = fetch;
			fetch:      nextState = decode;
			decode:
			begin
				case (opcode)
					opAdd, opSub, opNand: nextState = execArith;
					opShift:              nextState = execShift;
					opOri:                nextState = oriRead;
					opLoad:               nextState = loadRead;
					opStore:              nextState = storeExec;
					opBpz, opBz, opBnz:   nextState = branchExec;
					opNop:                nextState = nopExec;
					opStop:               nextState = halted;
					default:              nextState = resetState; // undefined byte
				endcase
			end
			execArith:  nextState = writeBack;
			execShift:  nextState = writeBack;
			oriRead:    nextState = oriExec;
			oriExec:    nextState = oriWrite;
			loadRead:   nextState = loadWrite;

			// last cycle of each instruction
			writeBack,
			oriWrite,
			loadWrite,
			storeExec,
			branchExec,
			nopExec:    nextState = fetch;

			halted:     nextState = halted; // only reset leaves
			default:    nextState = resetState;
		endcase
	end

	// ------------------------------------------------------------
	// state register and cycle counter
	// ------------------------------------------------------------
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state      <= resetState;
			cycleCount <= '0;
		end
		else
		begin
			state <= nextState;
			if (nextState != halted)
				cycleCount <= cycleCount + 1'b1; // frozen from halt entry on
		end
	end

endmodule

// File: logic/controlDecoder.sv
// Control word decoder
`timescale 1ns/1ps

module controlDecoder
(
	input  controlPkg::state_t       state,
	input  controlPkg::opcode_t      opcode,
	input  logic                     n,
	input  logic                     z,
	output controlPkg::controlWord_t control
);
	import controlPkg::*;

	// ------------------------------------------------------------
	// per-state control fields, everything else stays idle
	// ------------------------------------------------------------
	always_comb
	begin
		control = idleControl;
		case (state)
			fetch:
			begin
				control.pcWrite = 1'b1;   // pc <- pc + 1
				control.addrSel = 1'b1;   // address from pc
				control.memRead = 1'b1;
				control.irLoad  = 1'b1;
				control.alu2    = srcOne;
			end
			decode:
			begin
				control.r1r2Load = 1'b1;  // read both operands
			end
			execArith:
			begin
				control.alu1        = 1'b1;
				control.aluOutWrite = 1'b1;
				control.flagWrite   = 1'b1;
				case (opcode)
					opSub:   control.aluOp = aluSub;
					opNand:  control.aluOp = aluNand;
					default: control.aluOp = aluAdd;
				endcase
			end
			execShift:
			begin
				control.alu1        = 1'b1;
				control.alu2        = srcShiftImm;
				control.aluOp       = aluShift;
				control.aluOutWrite = 1'b1;
				control.flagWrite   = 1'b1;
			end
			writeBack:
			begin
				control.rfWrite = 1'b1;   // alu result to register
			end
			oriRead:
			begin
				control.r1Sel    = 1'b1;  // implicit k1 register
				control.r1r2Load = 1'b1;
			end
			oriExec:
			begin
				control.alu1        = 1'b1;
				control.alu2        = srcOriImm;
				control.aluOp       = aluOr;
				control.aluOutWrite = 1'b1;
				control.flagWrite   = 1'b1;
			end
			oriWrite:
			begin
				control.r1Sel   = 1'b1;
				control.rfWrite = 1'b1;
			end
			loadRead:
			begin
				control.memRead = 1'b1;
				control.mdrLoad = 1'b1;
			end
			loadWrite:
			begin
				control.aluOutWrite = 1'b1;
				control.rfWrite     = 1'b1;
				control.regIn       = 1'b1; // mdr to register file
			end
			storeExec:
			begin
				control.memWrite = 1'b1;
			end
			branchExec:
			begin
				control.alu2 = srcBranchImm; // pc + offset
				case (opcode)
					opBpz:   control.pcWrite = ~n;
					opBz:    control.pcWrite = z;
					opBnz:   control.pcWrite = ~z;
					default: control.pcWrite = 1'b0;
				endcase
			end

			// resetState, halted and nopExec issue no work
			default:
			begin
				control = idleControl;
			end
		endcase
	end

endmodule

// File: logic/controlUnit.sv
// Processor control unit top
`timescale 1ns/1ps

module controlUnit
(
	input  logic                     clock,
	input  logic                     reset,
	input  controlPkg::instr_t       instr,
	input  logic                     n,
	input  logic                     z,
	output controlPkg::controlWord_t control,
	output controlPkg::cycleCount_t  cycleCount
);
	import controlPkg::*;

	opcode_t opcode; // decoded from the held instruction
	state_t  state;

	// ------------------------------------------------------------
	// decode, sequence, drive
	// ------------------------------------------------------------
	instrDecoder i_instrDecoder
	(
		.instr  (instr),
		.opcode (opcode)
	);

	stateSequencer i_stateSequencer
	(
		.clock      (clock),
		.reset      (reset),
		.opcode     (opcode),
		.state      (state),
		.cycleCount (cycleCount)
	);

	controlDecoder i_controlDecoder
	(
		.state   (state),
		.opcode  (opcode),
		.n       (n),
		.z       (z),
		.control (control)
	);

endmodule

// File: verification/controlUnit_asserts.sv
// Control unit assertions
`timescale 1ns/1ps

module controlUnit_asserts
(
	input logic                     clock,
	input logic                     reset,
	input controlPkg::state_t       state,
	input controlPkg::controlWord_t control,
	input controlPkg::cycleCount_t  cycleCount
);
	import controlPkg::*;

	// ------------------------------------------------------------
	// sequencer properties
	// ------------------------------------------------------------
	haltedPersists: assert property (@(posedge clock) disable iff (reset)
		state == halted |=> state == halted)
		else $error("halted state left without a reset");

	countFrozen: assert property (@(posedge clock) disable iff (reset)
		state == halted |=> $stable(cycleCount))
		else $error("cycle counter moved while halted");

	// the release edge itself still holds resetState
	fetchAfterReset: assert property (@(posedge clock) disable iff (reset)
		state == resetState && !reset |=> state == fetch)
		else $error("resetState not followed by fetch");

	// a store never redirects the pc
	noPcWriteOnStore: assert property (@(posedge clock) disable iff (reset)
		!(control.pcWrite && control.memWrite))
		else $error("pcWrite and memWrite set together");

endmodule

bind controlUnit controlUnit_asserts i_controlUnit_asserts
(
	.clock      (clock),
	.reset      (reset),
	.state      (state),
	.control    (control),
	.cycleCount (cycleCount)
);

// File: verification/controlUnitTb.sv
// Control unit testbench
`timescale 1ns/1ps

module controlUnitTb;
	import controlPkg::*;

	localparam int cycleLimit = 400; // directed tests need about 140 cycles

	logic         clock;
	logic         reset;
	logic         n;
	logic         z;
	instr_t       instr;
	controlWord_t control;
	cycleCount_t  cycleCount;

	instr_t       nextInstr;  // applied on the following rising edge
	logic         nextN;
	logic         nextZ;
	state_t       modelState;
	opcode_t      modelOp;
	logic         modelN;
	logic         modelZ;
	cycleCount_t  modelCount;
	int           tbCycles = 0;

	controlUnit i_controlUnit
	(
		.clock      (clock),
		.reset      (reset),
		.instr      (instr),
		.n          (n),
		.z          (z),
		.control    (control),
		.cycleCount (cycleCount)
	);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	always @(posedge clock)
	begin
		tbCycles <= tbCycles + 1;
		if (tbCycles >= cycleLimit)
			failRun($sformatf("timeout, the run did not finish within %0d cycles", cycleLimit));
	end

	// ------------------------------------------------------------
	// reference model of the sequence
	// ------------------------------------------------------------
	function automatic state_t modelNext(state_t s, opcode_t op);
		state_t result;
		result = resetState;
		case (s)
			resetState: result = fetch;
			fetch:      result = decode;
			decode:
			begin
				if (op == opAdd || op == opSub || op == opNand)
					result = execArith;
				else if (op == opShift)
					result = execShift;
				else if (op == opOri)
					result = oriRead;
				else if (op == opLoad)
					result = loadRead;
				else if (op == opStore)
					result = storeExec;
				else if (op == opBpz || op == opBz || op == opBnz)
					result = branchExec;
				else if (op == opNop)
					result = nopExec;
				else if (op == opStop)
					result = halted;
			end
			execArith, execShift: result = writeBack;
			oriRead:    result = oriExec;
			oriExec:    result = oriWrite;
			loadRead:   result = loadWrite;
			halted:     result = halted;
			default:    result = fetch; // every final state
		endcase
		return result;
	endfunction

	function automatic controlWord_t expectedControl(state_t s, opcode_t op, logic nIn,
		logic zIn);
		controlWord_t w;
		w = idleControl;
		if (s == fetch)
		begin
			w.pcWrite = 1'b1;
			w.addrSel = 1'b1;
			w.memRead = 1'b1;
			w.irLoad  = 1'b1;
			w.alu2    = srcOne;
		end
		if (s == decode || s == oriRead)
			w.r1r2Load = 1'b1;
		if (s == execArith || s == execShift || s == oriExec)
		begin
			w.alu1        = 1'b1;
			w.aluOutWrite = 1'b1;
			w.flagWrite   = 1'b1;
		end
		if (s == execArith)
			w.aluOp = (op == opSub) ? aluSub : (op == opNand) ? aluNand : aluAdd;
		if (s == execShift)
		begin
			w.alu2  = srcShiftImm;
			w.aluOp = aluShift;
		end
		if (s == oriExec)
		begin
			w.alu2  = srcOriImm;
			w.aluOp = aluOr;
		end
		if (s == oriRead || s == oriWrite)
			w.r1Sel = 1'b1;
		if (s == writeBack || s == oriWrite || s == loadWrite)
			w.rfWrite = 1'b1;
		if (s == loadRead)
		begin
			w.memRead = 1'b1;
			w.mdrLoad = 1'b1;
		end
		if (s == loadWrite)
		begin
			w.aluOutWrite = 1'b1;
			w.regIn       = 1'b1;
		end
		if (s == storeExec)
			w.memWrite = 1'b1;
		if (s == branchExec)
		begin
			w.alu2    = srcBranchImm;
			w.pcWrite = (op == opBpz) ? !nIn : (op == opBz) ? zIn : !zIn;
		end
		return w;
	endfunction

	// ------------------------------------------------------------
	// checking and stepping
	// ------------------------------------------------------------
	task automatic failRun(string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
		if (actual !== expected)
			failRun($sformatf("mismatch %s: actual 0x%0h expected 0x%0h", name, actual,
				expected));
	endtask

	task automatic compareOutputs();
		checkValue($sformatf("control in %s", modelState.name()), 32'(control),
			32'(expectedControl(modelState, modelOp, modelN, modelZ)));
		checkValue("cycleCount", 32'(cycleCount), 32'(modelCount));
	endtask

	task automatic advance();
		state_t upcoming;
		@(posedge clock);
		instr <= nextInstr;
		n     <= nextN;
		z     <= nextZ;
		upcoming = modelNext(modelState, modelOp);
		if (upcoming != halted)
			modelCount = modelCount + 16'd1;
		modelState = upcoming;
		@(negedge clock); // outputs settled by now
		compareOutputs();
	endtask

	task automatic applyReset();
		@(posedge clock);
		reset <= 1'b1;
		modelState = resetState;
		modelCount = '0;
		@(negedge clock);
		compareOutputs();
		repeat (15)
		begin
			@(posedge clock);
			@(negedge clock);
			compareOutputs();
		end
		@(posedge clock);
		reset <= 1'b0; // sequencer still sees reset on this edge
		@(negedge clock);
		compareOutputs();
	endtask

	task automatic runInstr(instr_t code, opcode_t op, logic flagN, logic flagZ, int cycles,
		string label);
		cycleCount_t startCount;
		if (modelState != fetch)
			failRun($sformatf("%s was started outside of fetch", label));
		startCount = modelCount;
		nextInstr  = code;
		nextN      = flagN;
		nextZ      = flagZ;
		modelOp    = op;
		modelN     = flagN;
		modelZ     = flagZ;
		repeat (cycles)
			advance();
		if (modelState != fetch)
			failRun($sformatf("%s did not return to fetch after %0d cycles", label, cycles));
		checkValue($sformatf("cycleCount step of %s", label), 32'(cycleCount - startCount),
			32'(cycles));
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic resetSequence();
		applyReset();
		advance(); // first edge after release
		checkValue("cycleCount after first fetch", 32'(cycleCount), 32'd1);
	endtask

	task automatic arithmeticAndShift();
		runInstr(8'h34, opAdd, 1'b0, 1'b0, 4, "add");
		runInstr(8'h56, opSub, 1'b0, 1'b0, 4, "sub");
		runInstr(8'h78, opNand, 1'b0, 1'b0, 4, "nand");
		runInstr(8'h2b, opShift, 1'b0, 1'b0, 4, "shift");
	endtask

	task automatic oriLoadStore();
		runInstr(8'h4f, opOri, 1'b0, 1'b0, 5, "ori");
		runInstr(8'h60, opLoad, 1'b0, 1'b0, 4, "load");
		runInstr(8'h72, opStore, 1'b0, 1'b0, 3, "store");
	endtask

	task automatic branchFlags();
		logic [31:0] r;
		repeat (4)
		begin
			r = $urandom;
			runInstr(8'hcd, opBpz, r[0], r[1], 3, "bpz");
			r = $urandom;
			runInstr(8'h95, opBz, r[0], r[1], 3, "bz");
			r = $urandom;
			runInstr(8'hb9, opBnz, r[0], r[1], 3, "bnz");
		end
	endtask

	task automatic nopAndUndefined();
		runInstr(8'h81, opNop, 1'b0, 1'b0, 3, "nop");
		runInstr(8'h0a, opUndefined, 1'b0, 1'b0, 3, "vector byte 0x0a");
		runInstr(8'h3c, opUndefined, 1'b0, 1'b0, 3, "undefined byte 0x3c");
	endtask

	task automatic stopAndRestart();
		cycleCount_t frozen;
		nextInstr = 8'h01;
		modelOp   = opStop;
		advance();
		advance();
		if (modelState != halted)
			failRun("stop did not lead into the halted state");
		frozen = modelCount;
		repeat (20)
			advance();
		checkValue("cycleCount while halted", 32'(cycleCount), 32'(frozen));
		resetSequence();
		runInstr(8'h34, opAdd, 1'b0, 1'b0, 4, "add after restart");
	endtask

	initial
	begin
		void'($urandom(32'h6e16b2f8));
		reset      = 1'b1;
		instr      = 8'h81;
		n          = 1'b0;
		z          = 1'b0;
		nextInstr  = 8'h81; // nop until a test loads its own byte
		nextN      = 1'b0;
		nextZ      = 1'b0;
		modelState = resetState;
		modelOp    = opNop;
		modelN     = 1'b0;
		modelZ     = 1'b0;
		modelCount = '0;
		resetSequence();
		arithmeticAndShift();
		oriLoadStore();
		branchFlags();
		nopAndUndefined();
		stopAndRestart();
		$display("All tests passed");
		$finish;
	end

endmodule

// File: project.f
logic/controlPkg.sv
logic/instrDecoder.sv
logic/stateSequencer.sv
logic/controlDecoder.sv
logic/controlUnit.sv
verification/controlUnit_asserts.sv
verification/controlUnitTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the control unit testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module controlUnitTb \
	-f project.f -o controlUnitSim &&
./obj_dir/controlUnitSim ||
{
	echo "simulation failed"
	exit 1
}
